//--- common/hififo_pkg.sv
/* hififo TPC shared definitions
   packet sizes, data widths, host buffer descriptor, PCI TX beat and writer states */
`default_nettype none

package hififo_pkg;

   // packet geometry, one memory write carries 128 bytes
   localparam int TLP_QWORDS = 16; // payload qwords per TLP
   localparam int TLP_LEN_DW = 32; // header length field, dwords
   localparam int TLP_BEATS  = 18; // header beat + addr beat + 16 payload beats

   // buffer depths as log2
   localparam int FIFO_AW = 9; // 512 qwords of user data
   localparam int REQ_AW  = 2; // 4 descriptors

   typedef logic [63:0] qword_t;  // one user FIFO word
   typedef logic [60:0] qaddr_t;  // host address in 8 byte units
   typedef logic [18:0] qcount_t; // transfer length in qwords
   typedef logic [15:0] pci_id_t; // bus/dev/fn of this endpoint

   // one host buffer handed over by the request unit
   typedef struct packed {
      qaddr_t  addr;
      qcount_t count;     // multiple of TLP_QWORDS
      logic    interrupt; // pulse o_interrupt when the buffer is filled
   } tpc_request_t;

   // one 66 bit beat toward PCI TX
   // dwords go low half first
   typedef struct packed {
      logic   is_32; // last beat holds one dword only
      logic   eop;   // last beat of the TLP
      qword_t data;
   } tlp_beat_t;

   // writer FSM
   typedef enum logic [1:0] {
      ws_idle,   // waiting for a descriptor and 16 buffered qwords
      ws_header, // beat 0 on the bus, o_wr_valid high until granted
      ws_addr,   // beat 1, address dword(s)
      ws_data    // beats 2 to 17, payload
   } writer_state_t;

endpackage

`default_nettype wire

//--- hdl/fwft_fifo.sv
/* dual clock first word fall through FIFO
   gray coded pointers across domains, prefetched head word, almost empty level */
`timescale 1ns/10ps
`default_nettype none

module fwft_fifo
#(
   parameter int AW = 9
)
(
   input  wire                i_reset,
   // write side
   input  wire                i_clock,
   input  wire                i_valid,
   input  wire hififo_pkg::qword_t i_data,
   output logic               o_ready,
   // read side
   input  wire                o_clock,
   input  wire                o_read,
   output hififo_pkg::qword_t o_data,
   output logic               o_valid,
   output logic               o_almost_empty
);

   import hififo_pkg::*;

   localparam int DEPTH = 2 ** AW;

   function automatic logic [AW:0] bin2gray(input logic [AW:0] b);
      return b ^ (b >> 1);
   endfunction

   function automatic logic [AW:0] gray2bin(input logic [AW:0] g);
      logic [AW:0] b;
      b[AW] = g[AW];
      for (int i = AW - 1; i >= 0; i--)
         b[i] = b[i + 1] ^ g[i]; // running xor from msb down
      return b;
   endfunction

   qword_t mem [DEPTH];

   // write clock domain
   logic [1:0]  wr_reset_q;  // reset brought into i_clock
   logic        wr_reset;
   logic        wr_en;
   logic [AW:0] wr_bin;
   logic [AW:0] wr_bin_next;
   logic [AW:0] wr_gray;
   logic [AW:0] rd_gray_w1;
   logic [AW:0] rd_gray_w2;  // read pointer seen by writer

   // read clock domain
   logic [AW:0]   rd_bin;    // next RAM word to prefetch
   logic [AW:0]   rd_bin_next;
   logic [AW:0]   rd_gray;
   logic [AW:0]   wr_gray_r1;
   logic [AW:0]   wr_gray_r2;
   logic [AW:0]   wr_bin_r;  // write pointer seen by reader
   logic          ram_empty;
   logic          fetch;
   logic [AW:0]   ram_used;
   logic [AW+1:0] level;     // RAM words plus head register

   assign wr_reset = wr_reset_q[1];
   assign wr_en = i_valid && o_ready; // writes while full are dropped
   assign wr_bin_next = wr_bin + (AW + 1)'(wr_en);
   // full when the msbs differ and the rest match, in gray
   assign o_ready = (wr_gray != {~rd_gray_w2[AW:AW-1], rd_gray_w2[AW-2:0]});

   always_ff @(posedge i_clock)
      wr_reset_q <= {wr_reset_q[0], i_reset};

   always_ff @(posedge i_clock)
   begin
      if (wr_en)
         mem[wr_bin[AW-1:0]] <= i_data;
   end

   always_ff @(posedge i_clock)
   begin
      if (wr_reset)
      begin
         wr_bin <= '0;
         wr_gray <= '0;
         rd_gray_w1 <= '0;
         rd_gray_w2 <= '0;
      end
      else
      begin
         wr_bin <= wr_bin_next;
         wr_gray <= bin2gray(wr_bin_next);
         rd_gray_w1 <= rd_gray;    // two flop sync
         rd_gray_w2 <= rd_gray_w1;
      end
   end

   assign wr_bin_r = gray2bin(wr_gray_r2);
   assign ram_empty = (rd_bin == wr_bin_r);
   // refill the head register when it is free or being popped
   assign fetch = !ram_empty && (!o_valid || o_read);
   assign rd_bin_next = rd_bin + (AW + 1)'(fetch);
   assign ram_used = wr_bin_r - rd_bin; // modulo 2^(AW+1)
   assign level = {1'b0, ram_used} + (AW + 2)'(o_valid);
   assign o_almost_empty = (level < (AW + 2)'(TLP_QWORDS)); // less than one packet

   always_ff @(posedge o_clock)
   begin
      if (fetch)
         o_data <= mem[rd_bin[AW-1:0]];
   end

   always_ff @(posedge o_clock)
   begin
      if (i_reset)
      begin
         rd_bin <= '0;
         rd_gray <= '0;
         wr_gray_r1 <= '0;
         wr_gray_r2 <= '0;
         o_valid <= 1'b0;
      end
      else
      begin
         rd_bin <= rd_bin_next;
         rd_gray <= bin2gray(rd_bin_next);
         wr_gray_r1 <= wr_gray;
         wr_gray_r2 <= wr_gray_r1;
         o_valid <= fetch || (o_valid && !o_read);
      end
   end

   // source must watch o_ready
   a_write_full : assert property (@(posedge i_clock) disable iff (wr_reset)
      i_valid |-> o_ready)
      else $error("fwft_fifo: write while full, word dropped");

   // reader must wait for a valid head
   a_read_empty : assert property (@(posedge o_clock) disable iff (i_reset)
      o_read |-> o_valid)
      else $error("fwft_fifo: read while empty");

endmodule

`default_nettype wire

//--- tpc/tpc_request_queue.sv
/* TPC request queue
   holds host buffer descriptors ahead of the TLP writer, head shown with a valid level */
`timescale 1ns/10ps
`default_nettype none

module tpc_request_queue
(
   input  wire                       i_clock,
   input  wire                       i_reset,
   input  wire                       i_push,
   input  wire hififo_pkg::tpc_request_t i_req,
   output logic                      o_full,
   input  wire                       i_pop,
   output hififo_pkg::tpc_request_t  o_head,
   output logic                      o_head_valid
);

   import hififo_pkg::*;

   localparam int DEPTH = 2 ** REQ_AW;

   tpc_request_t      mem [DEPTH];
   logic [REQ_AW-1:0] wr_ptr;
   logic [REQ_AW-1:0] rd_ptr;
   logic [REQ_AW:0]   used;    // occupancy, 0 to DEPTH
   logic              push_ok;
   logic              pop_ok;

   assign o_full = (used == (REQ_AW + 1)'(DEPTH));
   assign o_head_valid = (used != '0);
   assign o_head = mem[rd_ptr];
   assign push_ok = i_push && !o_full; // extra strobes lost
   assign pop_ok = i_pop && o_head_valid;

   always_ff @(posedge i_clock)
   begin
      if (push_ok)
         mem[wr_ptr] <= i_req;
   end

   always_ff @(posedge i_clock)
   begin
      if (i_reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         used <= '0;
      end
      else
      begin
         if (push_ok)
            wr_ptr <= wr_ptr + 1'b1; // wraps
         if (pop_ok)
            rd_ptr <= rd_ptr + 1'b1;
         if (push_ok && !pop_ok)
            used <= used + 1'b1;
         else if (pop_ok && !push_ok)
            used <= used - 1'b1;
      end
   end

   a_push_full : assert property (@(posedge i_clock) disable iff (i_reset)
      i_push |-> !o_full)
      else $error("tpc_request_queue: push while full");

   // the writer only sends whole 128 byte packets
   a_whole_packets : assert property (@(posedge i_clock) disable iff (i_reset)
      i_push |-> (i_req.count % qcount_t'(TLP_QWORDS)) == '0)
      else $error("tpc_request_queue: count not a multiple of a packet");

endmodule

`default_nettype wire

//--- tpc/tpc_tlp_writer.sv
/* TPC TLP writer
   turns buffered qwords into 128 byte memory write TLPs for the current host buffer */
`timescale 1ns/10ps
`default_nettype none

module tpc_tlp_writer
(
   input  wire                       i_clock,
   input  wire                       i_reset,
   input  wire hififo_pkg::pci_id_t  i_pci_id,
   // descriptor queue head
   input  wire hififo_pkg::tpc_request_t i_req,
   input  wire                       i_req_valid,
   output logic                      o_req_pop,
   // data FIFO read side
   input  wire hififo_pkg::qword_t   i_fifo_data,
   input  wire                       i_fifo_almost_empty,
   output logic                      o_fifo_read,
   // PCI TX
   output logic                      o_wr_valid,
   input  wire                       i_wr_ready,
   output hififo_pkg::tlp_beat_t     o_wr_data,
   output logic                      o_interrupt,
   output logic [31:0]               o_status
);

   import hififo_pkg::*;

   localparam int BW = $clog2(TLP_BEATS);
   localparam logic [BW-1:0] LAST_BEAT = BW'(TLP_BEATS - 1);

   // PCIe payload is little endian per dword
   function automatic logic [31:0] es(input logic [31:0] x);
      return {x[7:0], x[15:8], x[23:16], x[31:24]};
   endfunction

   writer_state_t state;
   qaddr_t        addr;          // next packet's address
   qcount_t       count;         // qwords left in this buffer
   logic          int_flag;      // current buffer wants an interrupt
   logic [BW-1:0] beat;          // beat now on o_wr_data
   logic          is_32;         // 3DW header, payload shifted one dword
   qword_t        wr_data_next;  // staged beat or held dword
   logic [28:0]   byte_count;    // qwords sent
   logic [63:0]   wr_addr;
   logic          addr_hi_zero;
   logic [31:0]   hdr_dw0;
   logic [31:0]   hdr_dw1;
   logic          grant;
   logic          start;
   logic          advance;
   logic          last_load;

   assign wr_addr = {addr, 3'b000}; // byte address
   assign addr_hi_zero = (wr_addr[63:32] == 32'd0);
   // fmt 010 or 011 (with data), type 00000 memory, tc/attr zero, length
   assign hdr_dw0 = {2'b01, !addr_hi_zero, 5'b00000, 8'h00, 6'd0, 10'(TLP_LEN_DW)};
   assign hdr_dw1 = {i_pci_id, 8'h00, 8'hff}; // tag 0, all byte enables
   assign o_wr_valid = (state == ws_header);
   assign grant = o_wr_valid && i_wr_ready;
   assign start = (state == ws_idle) && (count != '0) && !i_fifo_almost_empty;
   assign advance = grant || (state == ws_addr) || ((state == ws_data) && (beat != LAST_BEAT));
   assign last_load = (beat == LAST_BEAT - 1'b1); // loading beat 17
   // qwords leave the FIFO on the grant and the next 15 cycles
   assign o_fifo_read = grant ||
                        (((state == ws_addr) || (state == ws_data)) &&
                         (beat < BW'(TLP_QWORDS)));
   // new buffer only once the old one is fully read
   assign o_req_pop = i_req_valid && (count == '0);
   assign o_status = {byte_count, 3'b000};

   always_ff @(posedge i_clock)
   begin
      if (i_reset)
      begin
         state <= ws_idle;
         beat <= '0;
         count <= '0;
         int_flag <= 1'b0;
         o_interrupt <= 1'b0;
         byte_count <= '0;
      end
      else
      begin
         o_interrupt <= int_flag && (count == qcount_t'(1)) && o_fifo_read; // last qword
         byte_count <= byte_count + 29'(o_fifo_read);
         if (o_req_pop)
         begin
            count <= i_req.count;
            int_flag <= i_req.interrupt;
         end
         else if (o_fifo_read)
            count <= count - qcount_t'(1);
         if (start)
            beat <= '0;
         else if (advance)
            beat <= beat + 1'b1;
         case (state)
            ws_idle:
               if (start)
                  state <= ws_header;
            ws_header:
               if (grant)
                  state <= ws_addr; // i_wr_ready ignored from here
            ws_addr:
               state <= ws_data;
            ws_data:
               if (beat == LAST_BEAT)
                  state <= ws_idle;
            default:
               state <= ws_idle;
         endcase
      end
   end

   // datapath, beat k+1 is loaded while beat k is on the bus
   always_ff @(posedge i_clock)
   begin
      if (o_req_pop)
         addr <= i_req.addr;
      else if (o_fifo_read)
         addr <= addr + qaddr_t'(1);
      if (start)
      begin
         is_32 <= addr_hi_zero;
         o_wr_data.is_32 <= 1'b0;
         o_wr_data.eop <= 1'b0;
         o_wr_data.data <= {hdr_dw1, hdr_dw0}; // held through a grant stall
         // 4DW address goes upper dword first
         wr_data_next <= addr_hi_zero ? {32'd0, wr_addr[31:0]} : {wr_addr[31:0], wr_addr[63:32]};
      end
      else if (advance)
      begin
         o_wr_data.eop <= last_load;
         o_wr_data.is_32 <= is_32 && last_load;
         if (!is_32)
            o_wr_data.data <= wr_data_next;
         else if (last_load)
            o_wr_data.data <= {32'd0, wr_data_next[31:0]}; // odd dword out
         else
            o_wr_data.data <= {es(i_fifo_data[31:0]), wr_data_next[31:0]};
         // 32 bit case keeps the upper dword for the next beat
         wr_data_next <= is_32 ? {32'd0, es(i_fifo_data[63:32])} :
                                 {es(i_fifo_data[63:32]), es(i_fifo_data[31:0])};
      end
   end

   // a full packet must be buffered before it is offered
   a_grant_data : assert property (@(posedge i_clock) disable iff (i_reset)
      grant |-> !i_fifo_almost_empty)
      else $error("tpc_tlp_writer: grant with less than a packet buffered");

   a_burst_len : assert property (@(posedge i_clock) disable iff (i_reset)
      grant |-> ##(TLP_BEATS - 1) o_wr_data.eop)
      else $error("tpc_tlp_writer: eop not on the last beat");

endmodule

`default_nettype wire

//--- hdl/hififo_tpc.sv
/* hififo TPC, FIFO to PCI Express memory write
   descriptor queue, dual clock data FIFO and TLP writer */
`timescale 1ns/10ps
`default_nettype none

module hififo_tpc
(
   input  wire                       clock,
   input  wire                       reset,
   input  wire hififo_pkg::pci_id_t  i_pci_id,
   // request unit
   input  wire                       i_req_valid,
   input  wire hififo_pkg::tpc_request_t i_req,
   output logic                      o_req_ready,
   // PCI TX
   output logic                      o_wr_valid,
   input  wire                       i_wr_ready,
   output hififo_pkg::tlp_beat_t     o_wr_data,
   // user FIFO, i_fifo_clock domain
   input  wire                       i_fifo_clock,
   input  wire                       i_fifo_write,
   input  wire hififo_pkg::qword_t   i_fifo_data,
   output logic                      o_fifo_ready,
   output logic                      o_interrupt,
   output logic [31:0]               o_status
);

   import hififo_pkg::*;

   tpc_request_t req_head;
   logic         req_head_valid;
   logic         req_pop;
   logic         req_full;
   qword_t       fifo_data;         // FIFO head word
   logic         fifo_read;
   logic         fifo_almost_empty; // under one packet buffered

   assign o_req_ready = !req_full;

   tpc_request_queue req_queue0
   (
      .i_clock      (clock),
      .i_reset      (reset),
      .i_push       (i_req_valid),
      .i_req        (i_req),
      .o_full       (req_full),
      .i_pop        (req_pop),
      .o_head       (req_head),
      .o_head_valid (req_head_valid)
   );

   fwft_fifo #(.AW(FIFO_AW)) data_fifo0
   (
      .i_reset        (reset),
      .i_clock        (i_fifo_clock),
      .i_valid        (i_fifo_write),
      .i_data         (i_fifo_data),
      .o_ready        (o_fifo_ready),
      .o_clock        (clock),
      .o_read         (fifo_read),
      .o_data         (fifo_data),
      .o_valid        (),
      .o_almost_empty (fifo_almost_empty)
   );

   tpc_tlp_writer writer0
   (
      .i_clock             (clock),
      .i_reset             (reset),
      .i_pci_id            (i_pci_id),
      .i_req               (req_head),
      .i_req_valid         (req_head_valid),
      .o_req_pop           (req_pop),
      .i_fifo_data         (fifo_data),
      .i_fifo_almost_empty (fifo_almost_empty),
      .o_fifo_read         (fifo_read),
      .o_wr_valid          (o_wr_valid),
      .i_wr_ready          (i_wr_ready),
      .o_wr_data           (o_wr_data),
      .o_interrupt         (o_interrupt),
      .o_status            (o_status)
   );

endmodule

`default_nettype wire

//--- testbench/hififo_tpc_tb.sv
/* hififo TPC testbench
   request table, LFSR data through the dual clock FIFO, TLP beat model and checks */
`timescale 1ns/10ps
`default_nettype none

module hififo_tpc_tb;

   import hififo_pkg::*;

   typedef struct packed {
      logic [63:0] addr;    // byte address, 128 byte aligned
      logic [7:0]  packets;
      logic        irq;
      logic [7:0]  stall;   // cycles beat 0 waits for i_wr_ready
   } row_t;

   // one expected TLP
   typedef struct packed {
      logic [63:0] addr;
      logic [7:0]  row;
      logic        last;    // final packet of its request
      logic [7:0]  stall;
   } pkt_t;

   localparam int NROWS = 8;
   localparam int NFILL = 5; // pushed back to back, queue full after these
   localparam pci_id_t PCI_ID = 16'h0a18;
   localparam row_t ROWS [NROWS] = '{
      '{64'h0000_0001_2345_6780, 8'd1, 1'b1, 8'd0}, // 4DW header
      '{64'h0000_0000_8000_1000, 8'd1, 1'b0, 8'd2}, // 3DW, shifted payload
      '{64'h0000_0000_0004_0000, 8'd3, 1'b1, 8'd0},
      '{64'h0000_00ff_fff0_0000, 8'd2, 1'b0, 8'd5},
      '{64'h0000_0000_1234_5600, 8'd2, 1'b1, 8'd1},
      '{64'h8000_0000_0000_0080, 8'd1, 1'b0, 8'd0},
      '{64'h0000_0000_0fff_ff80, 8'd2, 1'b1, 8'd3},
      '{64'h0000_0002_0000_0000, 8'd2, 1'b0, 8'd0}
   };

   logic         clock;
   logic         reset;
   pci_id_t      i_pci_id;
   logic         i_req_valid;
   tpc_request_t i_req;
   logic         o_req_ready;
   logic         o_wr_valid;
   logic         i_wr_ready;
   tlp_beat_t    o_wr_data;
   logic         i_fifo_clock;
   logic         i_fifo_write;
   qword_t       i_fifo_data;
   logic         o_fifo_ready;
   logic         o_interrupt;
   logic [31:0]  o_status;

   pkt_t        exp_q [$];   // packets not yet granted
   qword_t      data_q [$];  // words written, not yet sent
   qword_t      pkt_words [TLP_QWORDS];
   pkt_t        cur;
   logic [31:0] lfsr;
   logic        row_bad [NROWS];
   logic        in_burst;
   logic        prev_valid;
   logic        prev_ready;
   logic        ready_next;  // i_wr_ready for the next cycle
   logic        data_go;
   int          written_total;
   int          pkts_granted;
   int          int_seen;
   int          errors;
   int          rows_done;
   int          rows_failed;
   int          beat_idx;
   int          wait_cnt;
   int          cur_row;

   hififo_tpc dut0
   (
      .clock        (clock),
      .reset        (reset),
      .i_pci_id     (i_pci_id),
      .i_req_valid  (i_req_valid),
      .i_req        (i_req),
      .o_req_ready  (o_req_ready),
      .o_wr_valid   (o_wr_valid),
      .i_wr_ready   (i_wr_ready),
      .o_wr_data    (o_wr_data),
      .i_fifo_clock (i_fifo_clock),
      .i_fifo_write (i_fifo_write),
      .i_fifo_data  (i_fifo_data),
      .o_fifo_ready (o_fifo_ready),
      .o_interrupt  (o_interrupt),
      .o_status     (o_status)
   );

   function automatic int total_packets();
      int n;
      n = 0;
      for (int i = 0; i < NROWS; i++)
         n += int'(ROWS[i].packets);
      return n;
   endfunction

   function automatic int flagged_rows();
      int n;
      n = 0;
      for (int i = 0; i < NROWS; i++)
         n += int'(ROWS[i].irq);
      return n;
   endfunction

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output qword_t v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_next(lfsr);
         v = {v[62:0], lfsr[0]}; // newest bit
      end
   endtask

   function automatic logic [31:0] bswap(input logic [31:0] x);
      logic [31:0] y;
      for (int b = 0; b < 4; b++)
         y[8*b +: 8] = x[8*(3-b) +: 8];
      return y;
   endfunction

   // payload dword i of the current packet in PCIe order
   function automatic logic [31:0] payload_dw(input int i);
      qword_t w;
      w = pkt_words[i / 2];
      if (i % 2 == 0)
         return bswap(w[31:0]);
      return bswap(w[63:32]);
   endfunction

   function automatic tlp_beat_t expect_beat(input logic [63:0] a, input int k);
      tlp_beat_t   b;
      logic        wide;
      logic [31:0] dw0;
      logic [31:0] dw1;
      wide = (a[63:32] != 32'd0);
      // fmt 010 or 011, type MWr, length in dwords
      dw0 = {wide ? 3'b011 : 3'b010, 5'b00000, 8'h00, 6'd0, 10'(TLP_LEN_DW)};
      dw1 = {PCI_ID, 8'h00, 8'hff}; // tag 0, last/first BE
      b.eop = (k == TLP_BEATS - 1);
      b.is_32 = !wide && (k == TLP_BEATS - 1);
      if (k == 0)
         b.data = {dw1, dw0};
      else if (wide && k == 1)
         b.data = {a[31:0], a[63:32]}; // upper dword goes first
      else if (wide)
         b.data = {payload_dw(2*k - 3), payload_dw(2*k - 4)};
      else
      begin
         if (k == 1)
            b.data[31:0] = a[31:0];
         else
            b.data[31:0] = payload_dw(2*k - 3);
         if (k == TLP_BEATS - 1)
            b.data[63:32] = 32'd0; // odd dword left over
         else
            b.data[63:32] = payload_dw(2*k - 2);
      end
      return b;
   endfunction

   task automatic count_failure();
      errors++;
      if (cur_row >= 0)
         row_bad[cur_row] = 1'b1;
   endtask

   task automatic value_error(input string name, input logic [63:0] got, input logic [63:0] exp);
      $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      count_failure();
   endtask

   task automatic plain_error(input string what);
      $display("** Error at %0t ns: %s", $time, what);
      count_failure();
   endtask

   task automatic compare_beat(input int k);
      tlp_beat_t e;
      e = expect_beat(cur.addr, k);
      if (o_wr_data.data !== e.data)
         value_error($sformatf("o_wr_data.data beat %0d", k), o_wr_data.data, e.data);
      if (o_wr_data.eop !== e.eop)
         value_error($sformatf("o_wr_data.eop beat %0d", k), 64'(o_wr_data.eop), 64'(e.eop));
      if (o_wr_data.is_32 !== e.is_32)
         value_error($sformatf("o_wr_data.is_32 beat %0d", k), 64'(o_wr_data.is_32),
                     64'(e.is_32));
   endtask

   task automatic burst_beat();
      logic irq_due;
      beat_idx++;
      compare_beat(beat_idx);
      if (o_wr_valid)
         plain_error("o_wr_valid high during a burst");
      // pulse follows the 16th read of a flagged request
      irq_due = (beat_idx == TLP_QWORDS) && cur.last && ROWS[cur_row].irq;
      if (o_interrupt !== irq_due)
         value_error("o_interrupt", 64'(o_interrupt), 64'(irq_due));
      if (beat_idx == TLP_BEATS - 1)
      begin
         if (o_status !== 32'(pkts_granted * TLP_QWORDS * 8))
            value_error("o_status", 64'(o_status), 64'(pkts_granted * TLP_QWORDS * 8));
         in_burst = 1'b0;
         if (cur.last)
         begin
            rows_done++;
            if (row_bad[cur_row])
               rows_failed++;
            $display("test %0d: %0d packet(s) to %h, interrupt %0b, stall %0d: %s", cur_row,
                     ROWS[cur_row].packets, ROWS[cur_row].addr, ROWS[cur_row].irq,
                     ROWS[cur_row].stall, row_bad[cur_row] ? "pass failed" : "pass");
         end
         cur_row = -1;
      end
   endtask

   task automatic idle_cycle();
      if (o_interrupt)
         value_error("o_interrupt", 64'd1, 64'd0);
      if (!o_wr_valid)
      begin
         if (prev_valid && !prev_ready)
            plain_error("o_wr_valid fell before the grant");
      end
      else if (exp_q.size() == 0)
         plain_error("o_wr_valid high with no request queued");
      else
      begin
         cur = exp_q[0];
         cur_row = int'(cur.row);
         if (!prev_valid && written_total < TLP_QWORDS * (pkts_granted + 1))
            plain_error($sformatf("o_wr_valid rose with only %0d of %0d words written",
                                  written_total, TLP_QWORDS * (pkts_granted + 1)));
         compare_beat(0); // also while stalled
         if (i_wr_ready)
         begin
            void'(exp_q.pop_front());
            if (data_q.size() < TLP_QWORDS)
               plain_error("grant with fewer than 16 words written");
            for (int i = 0; i < TLP_QWORDS; i++)
               pkt_words[i] = (data_q.size() > 0) ? data_q.pop_front() : '0;
            pkts_granted++;
            in_burst = 1'b1;
            beat_idx = 0;
         end
      end
   endtask

   initial
   begin
      clock = 1'b0;
      forever #10 clock = ~clock;
   end

   initial
   begin
      i_fifo_clock = 1'b0;
      forever #7 i_fifo_clock = ~i_fifo_clock; // unrelated to clock
   end

   // TX monitor, outputs settle well before the falling edge
   always @(negedge clock)
   begin
      if (!reset)
      begin
         if (o_interrupt)
            int_seen++;
         if (in_burst)
            burst_beat();
         else
            idle_cycle();
         prev_valid = o_wr_valid;
         prev_ready = i_wr_ready;
         if (o_wr_valid && !i_wr_ready)
            wait_cnt++;
         else if (!o_wr_valid)
            wait_cnt = 0;
         ready_next = (exp_q.size() == 0) || (wait_cnt >= int'(exp_q[0].stall));
      end
   end

   always @(posedge clock)
      i_wr_ready <= ready_next;

   // writing into a full FIFO would lose a word
   always @(negedge i_fifo_clock)
   begin
      if (i_fifo_write && !o_fifo_ready)
         plain_error("FIFO write while o_fifo_ready is low");
   end

   // user data, random gaps
   initial
   begin
      qword_t r;
      qword_t w;
      wait (data_go);
      repeat (3) @(posedge i_fifo_clock);
      while (written_total < total_packets() * TLP_QWORDS)
      begin
         @(posedge i_fifo_clock);
         take_bits(1, r);
         if (r[0])
         begin
            take_bits(64, r);
            w = qword_t'(written_total) ^ r;
            i_fifo_write <= 1'b1;
            i_fifo_data <= w;
            data_q.push_back(w);
            written_total++;
         end
         else
            i_fifo_write <= 1'b0;
      end
      @(posedge i_fifo_clock);
      i_fifo_write <= 1'b0;
   end

   initial
   begin : watchdog
      repeat (total_packets() * 60 + 400) @(posedge clock);
      $display("** Error at %0t ns: timeout, %0d of %0d tests finished", $time, rows_done, NROWS);
      $display("ERRORS FOUND");
      $finish;
   end

   task automatic push_row(input int i);
      pkt_t p;
      i_req_valid <= 1'b1;
      i_req.addr <= ROWS[i].addr[63:3];
      i_req.count <= qcount_t'(ROWS[i].packets) * qcount_t'(TLP_QWORDS);
      i_req.interrupt <= ROWS[i].irq;
      for (int k = 0; k < int'(ROWS[i].packets); k++)
      begin
         p.addr = ROWS[i].addr + 64'(k * 128); // 128 bytes per packet
         p.row = 8'(i);
         p.last = (k == int'(ROWS[i].packets) - 1);
         p.stall = ROWS[i].stall;
         exp_q.push_back(p);
      end
   endtask

   initial
   begin
      reset = 1'b1;
      i_pci_id = PCI_ID;
      i_req_valid = 1'b0;
      i_req = '0;
      i_wr_ready = 1'b0;
      i_fifo_write = 1'b0;
      i_fifo_data = '0;
      lfsr = 32'h294c51e5;
      ready_next = 1'b0;
      data_go = 1'b0;
      in_burst = 1'b0;
      prev_valid = 1'b0;
      prev_ready = 1'b0;
      written_total = 0;
      pkts_granted = 0;
      int_seen = 0;
      errors = 0;
      rows_done = 0;
      rows_failed = 0;
      beat_idx = 0;
      wait_cnt = 0;
      cur_row = -1;
      for (int i = 0; i < NROWS; i++)
         row_bad[i] = 1'b0;
      repeat (4) @(posedge clock);
      reset <= 1'b0;
      @(negedge clock);
      if (o_req_ready !== 1'b1)
         value_error("o_req_ready", 64'(o_req_ready), 64'd1);
      if (o_fifo_ready !== 1'b1)
         value_error("o_fifo_ready", 64'(o_fifo_ready), 64'd1);
      if (o_status !== 32'd0)
         value_error("o_status", 64'(o_status), 64'd0);
      // no data yet, first descriptor loaded and the queue fills behind it
      for (int i = 0; i < NFILL; i++)
      begin
         @(posedge clock);
         push_row(i);
      end
      @(posedge clock);
      i_req_valid <= 1'b0;
      @(negedge clock);
      if (o_req_ready !== 1'b0)
         value_error("o_req_ready", 64'(o_req_ready), 64'd0);
      data_go = 1'b1;
      for (int i = NFILL; i < NROWS; i++)
      begin
         @(negedge clock);
         while (!o_req_ready)
            @(negedge clock);
         @(posedge clock);
         push_row(i);
         @(posedge clock);
         i_req_valid <= 1'b0;
      end
      wait (rows_done == NROWS);
      repeat (4) @(posedge clock);
      if (int_seen != flagged_rows())
         plain_error($sformatf("%0d interrupt pulses for %0d flagged requests",
                               int_seen, flagged_rows()));
      if (o_status !== 32'(total_packets() * 128))
         value_error("o_status", 64'(o_status), 64'(total_packets() * 128));
      if (exp_q.size() != 0 || data_q.size() != 0)
         plain_error("packets or words left over at the end");
      $display("%0d tests, %0d passed, %0d failed, %0d errors", NROWS, NROWS - rows_failed,
               rows_failed, errors);
      if (errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire

//--- hififo_tpc.f
common/hififo_pkg.sv
hdl/fwft_fifo.sv
tpc/tpc_request_queue.sv
tpc/tpc_tlp_writer.sv
hdl/hififo_tpc.sv
testbench/hififo_tpc_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the hififo TPC testbench with Verilator, run it, then search the log for the pass line
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal \
   --top-module hififo_tpc_tb -f hififo_tpc.f -o hififo_tpc_sim \
   && ./obj_dir/hififo_tpc_sim | tee "$LOG" \
   || { echo "build or run failed"; exit 1; }

grep -q "^NO ERRORS$" "$LOG" \
   && { echo "simulation passed"; exit 0; } \
   || { echo "simulation failed, see $LOG"; exit 1; }
